//--- filelist.f
src/uart_pkg.sv
src/byte_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_bram_ctrl.sv
verif/bram_model.sv
verif/tb_uart_bram_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds and runs the mailbox UART testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_uart_bram_ctrl \
    -f filelist.f \
    -o sim_tb_uart_bram_ctrl

output="$(./obj_dir/sim_tb_uart_bram_ctrl)"
echo "$output"

if grep -qx "Test passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- verif/tb_uart_bram_ctrl.sv
/* drives the mailbox through the host port of the RAM model and checks the serial line;
   every wait gives up after TIMEOUT_CYCLES clocks */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_bram_ctrl;
    import uart_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;

    logic                  s_axis = 1'b0;
    logic                  arst_n_i;
    logic                  loop_sel;
    logic                  drv_line;
    logic                  uart_rx;
    logic                  uart_tx;
    logic [MEM_WIDTH-1:0]  ram_rdata;
    logic [MEM_WIDTH-1:0]  ram_wdata;
    logic [ADDR_WIDTH-1:0] ram_addr;
    logic [BYTE_NUM-1:0]   ram_wr_en;
    logic [1:0]            host_addr;
    logic [MEM_WIDTH-1:0]  host_wdata;
    logic                  host_we;
    logic [MEM_WIDTH-1:0]  host_rdata;
    logic [15:0]           lfsr_q = 16'd51801;
    logic [7:0]            sent_q [$];
    int                    errors;
    int                    checks;
    int                    tests;

    always #10 s_axis = ~s_axis;

    assign uart_rx = loop_sel ? uart_tx : drv_line;      // loopback or own frame driver

    uart_bram_ctrl uart_bram_ctrl_i (
        .s_axis    (s_axis   ),
        .arst_n_i  (arst_n_i ),
        .uart_rx_i (uart_rx  ),
        .uart_tx_o (uart_tx  ),
        .data_i    (ram_rdata),
        .data_o    (ram_wdata),
        .addr_o    (ram_addr ),
        .wr_en_o   (ram_wr_en)
    );

    bram_model i_ram (
        .s_axis      (s_axis    ),
        .addr_i      (ram_addr  ),
        .data_i      (ram_wdata ),
        .wr_en_i     (ram_wr_en ),
        .data_o      (ram_rdata ),
        .host_addr_i (host_addr ),
        .host_data_i (host_wdata),
        .host_we_i   (host_we   ),
        .host_data_o (host_rdata)
    );

    // the acknowledge must write a zero command word
    a_ack_zero: assert property (@(posedge s_axis) disable iff (!arst_n_i)
        (ram_wr_en != '0 && ram_addr == CMD_ADDR) |-> ram_wdata == '0)
    else begin
        errors++;
        $display("[FAIL] %0t data_o got %h expected 0 during acknowledge", $time, ram_wdata);
    end

    // ====================
    // helpers
    // ====================
    task automatic tick();
        @(posedge s_axis);
        #2;
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic fail_timeout(string what);
        $display("timeout while waiting for %s", what);
        $display("Test failed");
        $finish;
    endtask

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            b[i]   = lfsr_q[0];
        end
    endtask

    task automatic issue_cmd(opcode_e op, logic [15:0] arg);
        mem_word_u w;
        int        cnt;
        w            = '0;
        w.cmd.opcode = op;
        w.cmd.arg    = arg;
        cnt          = 0;
        host_addr    = 2'(CMD_ADDR);
        host_wdata   = w;
        host_we      = 1'b1;
        tick();
        host_we = 1'b0;
        while (host_rdata !== '0) begin                   // acknowledge clears word 0
            if (cnt == TIMEOUT_CYCLES) fail_timeout("command acknowledge");
            cnt++;
            tick();
        end
    endtask

    task automatic read_result(output mem_word_u w);
        host_addr = 2'(RESULT_ADDR);
        #1;
        w         = host_rdata;
        host_addr = 2'(CMD_ADDR);
    endtask

    task automatic wait_line_low();
        int cnt;
        cnt = 0;
        @(negedge s_axis);
        while (uart_tx !== 1'b0) begin
            if (cnt == TIMEOUT_CYCLES) fail_timeout("a start bit on uart_tx_o");
            cnt++;
            @(negedge s_axis);
        end
    endtask

    task automatic wait_line_quiet(int div);
        int cnt;
        int high;
        cnt  = 0;
        high = 0;
        while (high < 12 * div) begin
            if (cnt == TIMEOUT_CYCLES) fail_timeout("an idle serial line");
            cnt++;
            @(negedge s_axis);
            high = (uart_tx === 1'b1) ? high + 1 : 0;
        end
    endtask

    // samples one frame at its bit centres
    task automatic monitor_frame(int div, parity_e par, output logic [7:0] b);
        logic exp_par;
        int   ones;
        wait_line_low();
        repeat (div / 2) @(negedge s_axis);
        check_value("uart_tx_o start bit", 32'(uart_tx), 32'd0);
        for (int i = 0; i < 8; i++) begin
            repeat (div) @(negedge s_axis);
            b[i] = uart_tx;
        end
        if (par != PAR_NONE) begin
            ones = 0;
            for (int i = 0; i < 8; i++) begin
                ones += b[i];
            end
            // even mode pads the count of ones to an even total and odd mode to an odd one
            exp_par = (par == PAR_EVEN) ? ones[0] : ~ones[0];
            repeat (div) @(negedge s_axis);
            check_value("uart_tx_o parity bit", 32'(uart_tx), 32'(exp_par));
        end
        repeat (div) @(negedge s_axis);
        check_value("uart_tx_o stop bit", 32'(uart_tx), 32'd1);
    endtask

    task automatic send_bytes(int n, int div, parity_e par);
        logic [7:0] b;
        sent_q.delete();
        for (int i = 0; i < n; i++) begin
            next_byte(b);
            sent_q.push_back(b);
        end
        fork
            begin
                for (int i = 0; i < n; i++) issue_cmd(OP_TX, {8'h00, sent_q[i]});
            end
            begin
                logic [7:0] got;
                for (int i = 0; i < n; i++) begin
                    monitor_frame(div, par, got);
                    check_value("uart_tx_o data", 32'(got), 32'(sent_q[i]));
                end
            end
        join
    endtask

    task automatic drive_frame(logic [7:0] b, int div, logic par_bit);
        logic [10:0] frame;
        frame = {1'b1, par_bit, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            drv_line = frame[i];
            repeat (div) tick();
        end
    endtask

    task automatic end_test(string name, int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "errors");
    endtask

    // ====================
    // tests
    // ====================
    initial begin
        mem_word_u  w;
        logic [7:0] b;
        int         e0;
        int         len;
        int         cnt;

        arst_n_i   = 1'b0;
        loop_sel   = 1'b0;
        drv_line   = 1'b1;
        host_addr  = '0;
        host_wdata = '0;
        host_we    = 1'b0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        repeat (4) tick();
        arst_n_i = 1'b1;

        e0 = errors;
        for (int i = 0; i < 40; i++) begin                // OP_NONE sits in word 0
            tick();
            check_value("uart_tx_o", 32'(uart_tx), 32'd1);
            check_value("wr_en_o", 32'(ram_wr_en), 32'd0);
            check_value("addr_o", 32'(ram_addr), 32'(CMD_ADDR));
        end
        end_test("reset and idle poll", e0);

        e0 = errors;
        issue_cmd(OP_SET_DIV, 16'd8);
        issue_cmd(OP_SET_PARITY, 16'(PAR_NONE));
        send_bytes(4, 8, PAR_NONE);
        issue_cmd(OP_SET_DIV, 16'd12);
        issue_cmd(OP_SET_PARITY, 16'(PAR_ODD));
        send_bytes(4, 12, PAR_ODD);
        end_test("transmit", e0);

        e0 = errors;
        issue_cmd(OP_SET_PARITY, 16'(PAR_NONE));
        issue_cmd(OP_SET_DIV, 16'd1);
        fork
            issue_cmd(OP_TX, 16'h0055);                   // LSB 1 ends the start bit
            begin
                wait_line_low();
                len = 0;
                while (uart_tx === 1'b0 && len < TIMEOUT_CYCLES) begin
                    len++;
                    @(negedge s_axis);
                end
            end
        join
        check_value("start bit length", 32'(len), 32'(MIN_DIVIDER));
        wait_line_quiet(int'(MIN_DIVIDER));
        end_test("divider clamp", e0);

        e0 = errors;
        issue_cmd(OP_SET_DIV, 16'd8);
        loop_sel = 1'b1;
        tick();
        send_bytes(4, 8, PAR_NONE);
        wait_line_quiet(8);
        for (int i = 0; i < 4; i++) begin
            issue_cmd(OP_RX, 16'h0000);
            read_result(w);
            check_value("result.rx_valid", 32'(w.result.rx_valid), 32'd1);
            check_value("result.par_err", 32'(w.result.par_err), 32'd0);
            check_value("result.data", 32'(w.result.data), 32'(sent_q[i]));
        end
        issue_cmd(OP_RX, 16'h0000);
        read_result(w);
        check_value("empty result word", w, 32'd0);
        end_test("loopback receive", e0);

        e0 = errors;
        loop_sel = 1'b0;
        tick();
        issue_cmd(OP_SET_PARITY, 16'(PAR_EVEN));
        next_byte(b);
        drive_frame(b, 8, ~(^b));                         // even parity would be ^b
        repeat (8) tick();
        issue_cmd(OP_RX, 16'h0000);
        read_result(w);
        check_value("result.rx_valid", 32'(w.result.rx_valid), 32'd1);
        check_value("result.par_err", 32'(w.result.par_err), 32'd1);
        check_value("result.data", 32'(w.result.data), 32'(b));
        end_test("parity error", e0);

        e0 = errors;
        issue_cmd(OP_SET_PARITY, 16'(PAR_NONE));
        issue_cmd(OP_SET_DIV, MIN_DIVIDER);
        send_bytes(FIFO_DEPTH + 2, int'(MIN_DIVIDER), PAR_NONE);
        cnt = 0;
        for (int i = 0; i < 12 * int'(MIN_DIVIDER); i++) begin   // a repeated byte shows up here
            @(negedge s_axis);
            if (uart_tx !== 1'b1) cnt++;
        end
        check_value("uart_tx_o low samples after last frame", 32'(cnt), 32'd0);
        wait_line_quiet(int'(MIN_DIVIDER));
        end_test("back-pressure", e0);

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/bram_model.sv
/* 4-word RAM with byte enables and one-cycle read latency; only address bits [1:0] are
   decoded, and the host port writes after the DUT port so it wins on a clash */
`timescale 1ns/1ps
`default_nettype none

module bram_model (
    input  logic                            s_axis,

    input  logic [uart_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [uart_pkg::MEM_WIDTH-1:0]  data_i,
    input  logic [uart_pkg::BYTE_NUM-1:0]   wr_en_i,
    output logic [uart_pkg::MEM_WIDTH-1:0]  data_o,

    input  logic [1:0]                      host_addr_i,
    input  logic [uart_pkg::MEM_WIDTH-1:0]  host_data_i,
    input  logic                            host_we_i,
    output logic [uart_pkg::MEM_WIDTH-1:0]  host_data_o
);
    import uart_pkg::*;

    logic [MEM_WIDTH-1:0] mem [4];

    initial begin
        for (int i = 0; i < 4; i++) mem[i] = '0;
        data_o = '0;
    end

    always @(posedge s_axis) begin
        data_o <= mem[addr_i[1:0]];                        // old word on a same-cycle write
        for (int b = 0; b < BYTE_NUM; b++) begin
            if (wr_en_i[b]) mem[addr_i[1:0]][b*8 +: 8] <= data_i[b*8 +: 8];
        end
        if (host_we_i) mem[host_addr_i] <= host_data_i;
    end

    assign host_data_o = mem[host_addr_i];

endmodule

`default_nettype wire

//--- src/uart_bram_ctrl.sv
/* owns the single RAM port and polls the command word; setting changes wait until both
   UART blocks are idle, and unknown opcodes are acknowledged without effect */
`timescale 1ns/1ps
`default_nettype none

module uart_bram_ctrl (
    input  logic                            s_axis,
    input  logic                            arst_n_i,

    input  logic                            uart_rx_i,
    output logic                            uart_tx_o,

    input  logic [uart_pkg::MEM_WIDTH-1:0]  data_i,
    output logic [uart_pkg::MEM_WIDTH-1:0]  data_o,
    output logic [uart_pkg::ADDR_WIDTH-1:0] addr_o,
    output logic [uart_pkg::BYTE_NUM-1:0]   wr_en_o
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        POLL,
        DECODE,
        WAIT_IDLE,
        PUSH,
        RESULT,
        ACK
    } state_e;

    state_e               state_q;
    cmd_word_t            cmd_q;
    uart_regs_t           regs_q;
    mem_word_u            rd_word;
    mem_word_u            wr_word;
    logic [DIV_WIDTH-1:0] div_arg;
    parity_e              par_arg;
    logic                 tx_idle;
    logic                 rx_idle;

    uart_byte_t tx_push_data;
    logic       tx_push_valid;
    logic       tx_push_ready;
    uart_byte_t tx_stream_data;
    logic       tx_stream_valid;
    logic       tx_stream_ready;
    uart_byte_t rx_stream_data;
    logic       rx_stream_valid;
    logic       rx_stream_ready;
    uart_byte_t rx_pop_data;
    logic       rx_pop_valid;
    logic       rx_pop_ready;

    assign rd_word = data_i;
    assign div_arg = (cmd_q.arg < MIN_DIVIDER) ? MIN_DIVIDER : cmd_q.arg;

    always_comb begin
        case (cmd_q.arg[1:0])
            2'd1:    par_arg = PAR_EVEN;
            2'd2:    par_arg = PAR_ODD;
            default: par_arg = PAR_NONE;                  // code 3 is taken as no parity
        endcase
    end

    // ====================
    // mailbox FSM
    // ====================
    always_ff @(posedge s_axis) begin
        if (state_q == DECODE) cmd_q <= rd_word.cmd;
    end

    always_ff @(posedge s_axis or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= POLL;
            regs_q  <= '{clk_divider: RESET_DIVIDER, parity: PAR_NONE};
        end else begin
            case (state_q)
                POLL: state_q <= DECODE;                  // data_i holds word 0 next cycle
                DECODE: begin
                    case (rd_word.cmd.opcode)
                        OP_NONE:                   state_q <= POLL;
                        OP_SET_DIV, OP_SET_PARITY: state_q <= WAIT_IDLE;
                        OP_TX:                     state_q <= PUSH;
                        OP_RX:                     state_q <= RESULT;
                        default:                   state_q <= ACK;
                    endcase
                end
                WAIT_IDLE: begin
                    if (tx_idle && rx_idle) begin
                        if (cmd_q.opcode == OP_SET_DIV) regs_q.clk_divider <= div_arg;
                        else                            regs_q.parity      <= par_arg;
                        state_q <= ACK;
                    end
                end
                PUSH: begin
                    if (tx_push_ready) state_q <= ACK;    // valid stays up while the FIFO is full
                end
                RESULT:  state_q <= ACK;
                default: state_q <= POLL;
            endcase
        end
    end

    always_comb begin
        addr_o  = CMD_ADDR;
        wr_en_o = '0;
        wr_word = '0;
        case (state_q)
            RESULT: begin
                addr_o  = RESULT_ADDR;
                wr_en_o = '1;
                if (rx_pop_valid) begin
                    wr_word.result.rx_valid = 1'b1;
                    wr_word.result.par_err  = rx_pop_data.par_err;
                    wr_word.result.data     = rx_pop_data.data;
                end
            end
            ACK:     wr_en_o = '1;                        // zero word clears the command
            default: wr_en_o = '0;
        endcase
    end

    assign data_o = wr_word;

    assign tx_push_data  = '{data: cmd_q.arg[BYTE_WIDTH-1:0], par_err: 1'b0};
    assign tx_push_valid = (state_q == PUSH);
    assign rx_pop_ready  = (state_q == RESULT);

    // ====================
    // datapath
    // ====================
    byte_fifo i_fifo_tx (
        .s_axis      (s_axis         ),
        .arst_n_i    (arst_n_i       ),
        .in_data_i   (tx_push_data   ),
        .in_valid_i  (tx_push_valid  ),
        .in_ready_o  (tx_push_ready  ),
        .out_data_o  (tx_stream_data ),
        .out_valid_o (tx_stream_valid),
        .out_ready_i (tx_stream_ready)
    );

    uart_tx i_uart_tx (
        .s_axis     (s_axis         ),
        .arst_n_i   (arst_n_i       ),
        .regs_i     (regs_q         ),
        .tx_data_i  (tx_stream_data ),
        .tx_valid_i (tx_stream_valid),
        .tx_ready_o (tx_stream_ready),
        .uart_tx_o  (uart_tx_o      ),
        .idle_o     (tx_idle        )
    );

    uart_rx i_uart_rx (
        .s_axis     (s_axis         ),
        .arst_n_i   (arst_n_i       ),
        .regs_i     (regs_q         ),
        .uart_rx_i  (uart_rx_i      ),
        .rx_data_o  (rx_stream_data ),
        .rx_valid_o (rx_stream_valid),
        .rx_ready_i (rx_stream_ready),
        .idle_o     (rx_idle        )
    );

    byte_fifo i_fifo_rx (
        .s_axis      (s_axis         ),
        .arst_n_i    (arst_n_i       ),
        .in_data_i   (rx_stream_data ),
        .in_valid_i  (rx_stream_valid),
        .in_ready_o  (rx_stream_ready),
        .out_data_o  (rx_pop_data    ),
        .out_valid_o (rx_pop_valid   ),
        .out_ready_i (rx_pop_ready   )
    );

    a_wr_en_all_or_none: assert property (@(posedge s_axis) disable iff (!arst_n_i)
        (wr_en_o == '0) || (wr_en_o == '1));

    a_divider_min: assert property (@(posedge s_axis) disable iff (!arst_n_i)
        regs_q.clk_divider >= MIN_DIVIDER);

endmodule

`default_nettype wire

//--- src/uart_rx.sv
/* samples each bit at its centre after a half-bit start check; the stop bit is not checked,
   and a byte is only offered when the FIFO can take it, otherwise it is lost */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                 s_axis,
    input  logic                 arst_n_i,

    input  uart_pkg::uart_regs_t regs_i,

    input  logic                 uart_rx_i,

    output uart_pkg::uart_byte_t rx_data_o,
    output logic                 rx_valid_o,
    input  logic                 rx_ready_i,

    output logic                 idle_o
);
    import uart_pkg::*;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    rx_state_e                state_q;
    logic [1:0]               sync_q;
    logic                     line_d_q;
    logic                     line;
    logic                     fall;
    logic                     tick;
    logic [DIV_WIDTH-1:0]     baud_cnt_q;
    logic [DIV_WIDTH-1:0]     div_q;
    parity_e                  par_q;
    logic [2:0]               bit_cnt_q;
    logic [BYTE_WIDTH-1:0]    data_q;
    logic                     par_err_q;
    logic                     valid_q;

    assign line = sync_q[1];
    assign fall = line_d_q & ~line;
    assign tick = (baud_cnt_q == '0);

    // ====================
    // frame settings and payload
    // ====================
    always_ff @(posedge s_axis) begin
        if (state_q == RX_IDLE) begin
            div_q     <= regs_i.clk_divider;              // frozen for the whole frame
            par_q     <= regs_i.parity;
            par_err_q <= 1'b0;
        end
        if (state_q == RX_DATA && tick) begin
            data_q <= {line, data_q[BYTE_WIDTH-1:1]};     // LSB arrives first
        end
        if (state_q == RX_PARITY && tick) begin
            par_err_q <= (^data_q) ^ line ^ (par_q == PAR_ODD);
        end
    end

    // ====================
    // frame FSM
    // ====================
    always_ff @(posedge s_axis or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q     <= 2'b11;
            line_d_q   <= 1'b1;
            state_q    <= RX_IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            valid_q    <= 1'b0;
        end else begin
            sync_q   <= {sync_q[0], uart_rx_i};
            line_d_q <= line;
            valid_q  <= 1'b0;

            if (state_q == RX_IDLE) begin
                baud_cnt_q <= (regs_i.clk_divider >> 1) - 1'b1;   // half a bit to the centre
            end else if (tick) begin
                baud_cnt_q <= div_q - 1'b1;
            end else begin
                baud_cnt_q <= baud_cnt_q - 1'b1;
            end

            case (state_q)
                RX_IDLE: begin
                    if (fall) state_q <= RX_START;
                end
                RX_START: begin
                    if (tick) begin
                        bit_cnt_q <= '0;
                        state_q   <= line ? RX_IDLE : RX_DATA;     // glitch, not a start bit
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'(BYTE_WIDTH - 1)) begin
                            state_q <= (par_q == PAR_NONE) ? RX_STOP : RX_PARITY;
                        end
                    end
                end
                RX_PARITY: begin
                    if (tick) state_q <= RX_STOP;
                end
                default: begin
                    if (tick) begin
                        valid_q <= rx_ready_i;
                        state_q <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    assign rx_data_o  = '{data: data_q, par_err: par_err_q};
    assign rx_valid_o = valid_q;
    assign idle_o     = (state_q == RX_IDLE);

    a_valid_one_cycle: assert property (@(posedge s_axis) disable iff (!arst_n_i)
        rx_valid_o |=> !rx_valid_o);

endmodule

`default_nettype wire

//--- src/uart_tx.sv
/* one start bit, 8 data bits LSB first, optional parity, one stop bit; the divider is
   captured when a byte is taken, so a frame keeps one speed throughout */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                 s_axis,
    input  logic                 arst_n_i,

    input  uart_pkg::uart_regs_t regs_i,

    input  uart_pkg::uart_byte_t tx_data_i,
    input  logic                 tx_valid_i,
    output logic                 tx_ready_o,

    output logic                 uart_tx_o,
    output logic                 idle_o
);
    import uart_pkg::*;

    logic                     busy_q;
    logic                     line_q;
    logic [FRAME_BITS-2:0]    shift_q;      // bits that follow the one on the line
    logic [BIT_CNT_WIDTH-1:0] bit_cnt_q;
    logic [DIV_WIDTH-1:0]     baud_cnt_q;
    logic [DIV_WIDTH-1:0]     div_q;
    logic                     load;
    logic                     par_bit;
    logic [FRAME_BITS-1:0]    frame;

    assign load = tx_valid_i & tx_ready_o;

    // even parity makes the count of ones even, odd makes it odd
    assign par_bit = (regs_i.parity == PAR_ODD) ? ~(^tx_data_i.data) : ^tx_data_i.data;

    assign frame = {1'b1,
                    (regs_i.parity == PAR_NONE) ? 1'b1 : par_bit,
                    tx_data_i.data,
                    1'b0};

    always_ff @(posedge s_axis) begin
        if (load) begin
            shift_q <= frame[FRAME_BITS-1:1];
            div_q   <= regs_i.clk_divider;
        end else if (busy_q && baud_cnt_q == '0) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge s_axis or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q     <= 1'b0;
            line_q     <= 1'b1;
            bit_cnt_q  <= '0;
            baud_cnt_q <= '0;
        end else if (load) begin
            busy_q     <= 1'b1;
            line_q     <= frame[0];                       // start bit goes out at once
            bit_cnt_q  <= (regs_i.parity == PAR_NONE) ? BIT_CNT_WIDTH'(FRAME_BITS - 2)
                                                      : BIT_CNT_WIDTH'(FRAME_BITS - 1);
            baud_cnt_q <= regs_i.clk_divider - 1'b1;
        end else if (busy_q) begin
            if (baud_cnt_q != '0) begin
                baud_cnt_q <= baud_cnt_q - 1'b1;
            end else if (bit_cnt_q == '0) begin
                busy_q     <= 1'b0;                       // stop bit has had its full length
            end else begin
                line_q     <= shift_q[0];
                bit_cnt_q  <= bit_cnt_q - 1'b1;
                baud_cnt_q <= div_q - 1'b1;
            end
        end
    end

    assign tx_ready_o = ~busy_q;
    assign idle_o     = ~busy_q;
    assign uart_tx_o  = line_q;

    a_idle_line_high: assert property (@(posedge s_axis) disable iff (!arst_n_i)
        idle_o |-> uart_tx_o);

endmodule

`default_nettype wire

//--- src/byte_fifo.sv
/* single-clock byte FIFO with valid/ready on both sides; the output is read straight from
   the register array, so a written entry shows up on the next cycle */
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
    input  logic                 s_axis,
    input  logic                 arst_n_i,

    input  uart_pkg::uart_byte_t in_data_i,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,

    output uart_pkg::uart_byte_t out_data_o,
    output logic                 out_valid_o,
    input  logic                 out_ready_i
);
    import uart_pkg::*;

    uart_byte_t                mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
    logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
    logic [FIFO_CNT_WIDTH-1:0] count_q;
    logic                      push;
    logic                      pop;

    assign in_ready_o  = (count_q != FIFO_CNT_WIDTH'(FIFO_DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_data_o  = mem_q[rd_ptr_q];

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    always_ff @(posedge s_axis) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

    always_ff @(posedge s_axis or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;      // wraps, depth is a power of two
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge s_axis) disable iff (!arst_n_i)
        count_q <= FIFO_CNT_WIDTH'(FIFO_DEPTH));

    a_out_stable: assert property (@(posedge s_axis) disable iff (!arst_n_i)
        out_valid_o && !out_ready_i |=> $stable(out_data_o));

endmodule

`default_nettype wire

//--- src/uart_pkg.sv
/* shared widths, opcodes and word layouts of the mailbox UART; RAM words are 32 bits wide
   with 4 byte enables, and FIFO_DEPTH must be a power of two */
`default_nettype none

package uart_pkg;

    // ====================
    // sizes
    // ====================
    localparam int MEM_WIDTH      = 32;
    localparam int BYTE_NUM       = 4;
    localparam int ADDR_WIDTH     = 8;
    localparam int BYTE_WIDTH     = 8;
    localparam int DIV_WIDTH      = 16;
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam int FRAME_BITS     = BYTE_WIDTH + 3;       // start, data, parity, stop
    localparam int BIT_CNT_WIDTH  = $clog2(FRAME_BITS);

    localparam logic [ADDR_WIDTH-1:0] CMD_ADDR      = ADDR_WIDTH'(0);
    localparam logic [ADDR_WIDTH-1:0] RESULT_ADDR   = ADDR_WIDTH'(1);
    localparam logic [DIV_WIDTH-1:0]  MIN_DIVIDER   = DIV_WIDTH'(4);
    localparam logic [DIV_WIDTH-1:0]  RESET_DIVIDER = DIV_WIDTH'(16);

    typedef enum logic [7:0] {
        OP_NONE       = 8'd0,
        OP_SET_DIV    = 8'd1,
        OP_SET_PARITY = 8'd2,
        OP_TX         = 8'd3,
        OP_RX         = 8'd4
    } opcode_e;

    typedef enum logic [1:0] {
        PAR_NONE = 2'd0,
        PAR_EVEN = 2'd1,
        PAR_ODD  = 2'd2
    } parity_e;

    typedef struct packed {
        logic [DIV_WIDTH-1:0] clk_divider;  // clocks per bit
        parity_e              parity;
    } uart_regs_t;

    typedef struct packed {
        logic [BYTE_WIDTH-1:0] data;
        logic                  par_err;     // always 0 towards the transmitter
    } uart_byte_t;

    // ====================
    // mailbox words
    // ====================
    typedef struct packed {
        opcode_e                opcode;
        logic [7:0]             reserved;
        logic [DIV_WIDTH-1:0]   arg;
    } cmd_word_t;

    typedef struct packed {
        logic                   rx_valid;
        logic                   par_err;
        logic [21:0]            reserved;
        logic [BYTE_WIDTH-1:0]  data;
    } result_word_t;

    typedef union packed {
        cmd_word_t    cmd;
        result_word_t result;
    } mem_word_u;

endpackage

`default_nettype wire
